// File: hdl/rv_pkg.sv
// -----------------------------------------------
// RV32I core shared definitions
// -----------------------------------------------
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
// -----------------------------------------------
// Program counter and next-PC select
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            jump_en,
    input  logic [XLEN-1:0] jump_target,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] snpc
);

    logic [XLEN-1:0] dnpc;

    assign snpc = pc + 32'd4;  // Sequential successor
    assign dnpc = jump_en ? jump_target : snpc;

    // Taken jumps override the sequential PC
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
// -----------------------------------------------
// Instruction decode
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decode_unit
    import rv_pkg::*;
(
    input  logic [XLEN-1:0]       inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [2:0]            funct3,
    output logic [XLEN-1:0]       imm,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic                  use_imm,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  is_lui,
    output logic                  is_auipc,
    output logic                  writes_rd
);

    inst_u               word;
    logic [6:0]          opcode;
    logic                is_reg_op;
    logic [ALU_OP_W-1:0] arith_op;

    assign word   = inst_u'(inst);
    assign opcode = word.r_fmt.opcode;

    // Register fields sit at the same place in every format
    assign rs1    = word.r_fmt.rs1;
    assign rs2    = word.r_fmt.rs2;
    assign rd     = word.r_fmt.rd;
    assign funct3 = word.r_fmt.funct3;

    assign is_reg_op = (opcode == OPC_OP);

    // Arithmetic op from funct3, funct7 bit 5 picks SUB and SRA
    always_comb begin
        case (word.r_fmt.funct3)
            3'b000:  arith_op = (is_reg_op && word.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = word.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR: imm = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            OPC_BRANCH: imm = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                               word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {word.u_fmt.imm_31_12, 12'b0};
            OPC_JAL: imm = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                            word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op    = ALU_ADD;  // Address and upper-immediate forms add
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_lui    = 1'b0;
        is_auipc  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op    = arith_op;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = arith_op;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LUI: begin
                is_lui    = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                is_auipc  = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_JAL: begin
                is_jal    = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_JALR: begin
                is_jalr   = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;  // ALU forms the target
                use_imm   = 1'b1;
            end
            default: ;  // Unknown opcode acts as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// -----------------------------------------------
// General purpose register file
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    // x1 to x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// -----------------------------------------------
// Execute and writeback select
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import rv_pkg::*;
(
    input  logic                  reset,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       snpc,
    input  logic [XLEN-1:0]       rdata1,
    input  logic [XLEN-1:0]       rdata2,
    input  logic [XLEN-1:0]       imm,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [2:0]            funct3,
    input  logic [ALU_OP_W-1:0]   alu_op,
    input  logic                  use_imm,
    input  logic                  is_branch,
    input  logic                  is_jal,
    input  logic                  is_jalr,
    input  logic                  is_lui,
    input  logic                  is_auipc,
    input  logic                  writes_rd,
    output logic                  jump_en,
    output logic [XLEN-1:0]       jump_target,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [4:0]      shamt;
    logic            taken;

    // Operand A is zero for LUI and the PC for PC-relative forms
    always_comb begin
        if (is_lui) begin
            alu_a = '0;
        end else if (is_auipc || is_jal || is_branch) begin
            alu_a = pc;
        end else begin
            alu_a = rdata1;
        end
    end

    assign alu_b = use_imm ? imm : rdata2;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = '0;
        endcase
    end

    // Branch conditions compare the source registers directly
    always_comb begin
        case (funct3)
            3'b000:  taken = (rdata1 == rdata2);                    // BEQ
            3'b001:  taken = (rdata1 != rdata2);                    // BNE
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));   // BLT
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));  // BGE
            3'b110:  taken = (rdata1 < rdata2);                     // BLTU
            3'b111:  taken = (rdata1 >= rdata2);                    // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign jump_en     = is_jal || is_jalr || (is_branch && taken);
    assign jump_target = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

    // Link address for jumps, ALU result otherwise
    assign wb_data = (is_jal || is_jalr) ? snpc : alu_result;
    assign wb_rd   = rd;
    assign wb_en   = writes_rd && (rd != '0) && !reset;  // Never writes x0

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
// -----------------------------------------------
// Single-cycle RV32I core
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       inst,
    output logic [XLEN-1:0]       pc,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]       snpc;
    logic                  jump_en;
    logic [XLEN-1:0]       jump_target;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  use_imm;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  writes_rd;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .jump_en    (jump_en),
        .jump_target(jump_target),
        .pc         (pc),
        .snpc       (snpc)
    );

    decode_unit decode_unit_inst (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .funct3   (funct3),
        .imm      (imm),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .is_branch(is_branch),
        .is_jal   (is_jal),
        .is_jalr  (is_jalr),
        .is_lui   (is_lui),
        .is_auipc (is_auipc),
        .writes_rd(writes_rd)
    );

    // Written from the execute writeback
    reg_file reg_file_inst (
        .clk   (clk),
        .we    (wb_en),
        .waddr (wb_rd),
        .wdata (wb_data),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    exec_unit exec_unit_inst (
        .reset      (reset),
        .pc         (pc),
        .snpc       (snpc),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .imm        (imm),
        .rd         (rd),
        .funct3     (funct3),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .is_lui     (is_lui),
        .is_auipc   (is_auipc),
        .writes_rd  (writes_rd),
        .jump_en    (jump_en),
        .jump_target(jump_target),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// File: test/core_assert.sv
// -----------------------------------------------
// Core port assertions
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_assert
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       pc,
    input  logic                  wb_en,
    input  logic [REG_ADDR_W-1:0] wb_rd
);

    no_x0_write: assert property (@(posedge clk) wb_en |-> (wb_rd != '0))
        else $error("writeback enabled with destination x0");

    reset_blocks_wb: assert property (@(posedge clk) reset |-> !wb_en)
        else $error("writeback enabled during reset");

    // Targets are at least halfword aligned
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else $error("pc has bit 0 set");

    pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> (pc == RESET_PC))
        else $error("pc is not the reset address after reset");

endmodule

bind rv_core core_assert #(
    .RESET_PC(RESET_PC)
) core_assert_inst (
    .clk  (clk),
    .reset(reset),
    .pc   (pc),
    .wb_en(wb_en),
    .wb_rd(wb_rd)
);

`default_nettype wire

// File: test/core_tb.sv
// -----------------------------------------------
// RV32I core testbench
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_tb
    import rv_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
    localparam int CLK_HALF       = 50;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_INSTR      = 2000;
    localparam int PRELOAD_INSTR  = 62;  // LUI plus ADDI for x1 to x31
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + NUM_INSTR / 10;

    logic                  clk;
    logic                  reset;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    // Reference architectural state
    logic [XLEN-1:0] model_regs [0:31];
    logic [XLEN-1:0] model_pc;
    integer          seed;
    int              wb_errors   = 0;
    int              pc_errors   = 0;
    int              cycle_count = 0;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) rv_core_inst (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .pc     (pc),
        .wb_en  (wb_en),
        .wb_rd  (wb_rd),
        .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic inst_u encode_r(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [6:0] f7);
        inst_u w;
        w              = '0;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = opc;
        return w;
    endfunction

    function automatic inst_u encode_i(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        inst_u w;
        w                = '0;
        w.i_fmt.imm_11_0 = imm;
        w.i_fmt.rs1      = rs1;
        w.i_fmt.funct3   = f3;
        w.i_fmt.rd       = rd;
        w.i_fmt.opcode   = opc;
        return w;
    endfunction

    // Offset bit 0 is dropped by the format
    function automatic inst_u encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
        inst_u w;
        w                = '0;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.rs2      = rs2;
        w.b_fmt.rs1      = rs1;
        w.b_fmt.funct3   = f3;
        w.b_fmt.imm_4_1  = off[4:1];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.opcode   = OPC_BRANCH;
        return w;
    endfunction

    function automatic inst_u encode_u(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [19:0] upper);
        inst_u w;
        w                 = '0;
        w.u_fmt.imm_31_12 = upper;
        w.u_fmt.rd        = rd;
        w.u_fmt.opcode    = opc;
        return w;
    endfunction

    function automatic inst_u encode_j(input logic [4:0] rd, input logic [20:0] off);
        inst_u w;
        w                 = '0;
        w.j_fmt.imm_20    = off[20];
        w.j_fmt.imm_10_1  = off[10:1];
        w.j_fmt.imm_11    = off[11];
        w.j_fmt.imm_19_12 = off[19:12];
        w.j_fmt.rd        = rd;
        w.j_fmt.opcode    = OPC_JAL;
        return w;
    endfunction

    function automatic logic is_known(input logic [6:0] opc);
        return (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI) ||
               (opc == OPC_AUIPC) || (opc == OPC_JAL) || (opc == OPC_JALR) ||
               (opc == OPC_BRANCH);
    endfunction

    // RV32I arithmetic by funct3, alt selects SUB or SRA
    function automatic logic [XLEN-1:0] model_arith(input logic [2:0] f3, input logic alt,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic [XLEN-1:0]        sra;
        logic [XLEN-1:0]        res;
        logic [4:0]             sh;
        sa  = a;
        sh  = b[4:0];
        sra = sa >>> sh;
        case (f3)
            3'b000:  res = alt ? (a - b) : (a + b);
            3'b001:  res = a << sh;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? sra : (a >> sh);
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_pc(input logic [XLEN-1:0] exp_pc);
        if (pc !== exp_pc) begin
            $display("ERR %0t: pc is %h, expected %h", $time, pc, exp_pc);
            pc_errors++;
        end
    endtask

    task automatic check_wb(input logic exp_en, input logic [REG_ADDR_W-1:0] exp_rd,
                            input logic [XLEN-1:0] exp_data);
        if (wb_en !== exp_en) begin
            $display("ERR %0t: wb_en is %b, expected %b", $time, wb_en, exp_en);
            wb_errors++;
        end else if (exp_en && ((wb_rd !== exp_rd) || (wb_data !== exp_data))) begin
            $display("ERR %0t: writeback x%0d = %h, expected x%0d = %h",
                     $time, wb_rd, wb_data, exp_rd, exp_data);
            wb_errors++;
        end
    endtask

    // Drive on the rising edge, check at the falling edge
    task automatic drive_and_check(input inst_u word, input logic exp_en,
                                   input logic [REG_ADDR_W-1:0] exp_rd,
                                   input logic [XLEN-1:0] exp_data,
                                   input logic [XLEN-1:0] exp_next);
        @(posedge clk);
        reset <= 1'b0;  // First call releases reset
        inst  <= word;
        @(negedge clk);
        check_pc(model_pc);
        check_wb(exp_en, exp_rd, exp_data);
        if (exp_en) begin
            model_regs[exp_rd] = exp_data;
        end
        model_pc = exp_next;
    endtask

    // Gives every register a known random value
    task automatic load_registers();
        logic [19:0]     upper;
        logic [11:0]     lower;
        logic [XLEN-1:0] value;
        logic [4:0]      rd;
        for (int i = 1; i < 32; i++) begin
            rd    = 5'(i);
            upper = 20'($random(seed));
            lower = 12'($random(seed));
            value = {upper, 12'b0};
            drive_and_check(encode_u(OPC_LUI, rd, upper), 1'b1, rd, value, model_pc + 32'd4);
            value = value + {{20{lower[11]}}, lower};
            drive_and_check(encode_i(OPC_OP_IMM, rd, 3'b000, rd, lower), 1'b1, rd, value,
                            model_pc + 32'd4);
        end
    endtask

    task automatic run_random();
        logic [31:0]           r;
        logic [31:0]           f;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [2:0]            f3;
        logic [11:0]           imm12;
        logic [12:0]           off13;
        logic [20:0]           off21;
        logic [6:0]            opc;
        logic                  alt;
        logic                  en;
        logic [XLEN-1:0]       res;
        logic [XLEN-1:0]       next_pc;
        logic [XLEN-1:0]       target;
        inst_u                 word;
        r       = $random(seed);
        f       = $random(seed);
        rd      = f[4:0];
        rs1     = f[9:5];
        rs2     = f[14:10];
        f3      = f[17:15];
        imm12   = f[29:18];
        en      = 1'b0;
        res     = '0;
        next_pc = model_pc + 32'd4;
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                alt  = r[4];
                word = encode_r(OPC_OP, rd, f3, rs1, rs2, {1'b0, alt, 5'b0});
                res  = model_arith(f3, alt, model_regs[rs1], model_regs[rs2]);
                en   = (rd != '0);
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                alt  = (f3 == 3'b101) && imm12[10];  // SRAI
                word = encode_i(OPC_OP_IMM, rd, f3, rs1, imm12);
                res  = model_arith(f3, alt, model_regs[rs1], {{20{imm12[11]}}, imm12});
                en   = (rd != '0);
            end
            4'd9: begin
                word = encode_u(OPC_LUI, rd, r[31:12]);
                res  = {r[31:12], 12'b0};
                en   = (rd != '0);
            end
            4'd10: begin
                word = encode_u(OPC_AUIPC, rd, r[31:12]);
                res  = model_pc + {r[31:12], 12'b0};
                en   = (rd != '0);
            end
            4'd11, 4'd12: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;  // Keep to the six valid conditions
                end
                if (r[5:4] == 2'b00) begin
                    rs2 = rs1;
                end
                off13 = {r[31:20], 1'b0};
                word  = encode_b(f3, rs1, rs2, off13);
                if (model_branch(f3, model_regs[rs1], model_regs[rs2])) begin
                    next_pc = model_pc + {{19{off13[12]}}, off13};
                end
            end
            4'd13: begin
                off21   = {r[31:12], 1'b0};
                word    = encode_j(rd, off21);
                res     = model_pc + 32'd4;
                en      = (rd != '0);
                next_pc = model_pc + {{11{off21[20]}}, off21};
            end
            4'd14: begin
                word    = encode_i(OPC_JALR, rd, 3'b000, rs1, imm12);
                target  = model_regs[rs1] + {{20{imm12[11]}}, imm12};
                res     = model_pc + 32'd4;
                en      = (rd != '0);
                next_pc = {target[XLEN-1:1], 1'b0};
            end
            default: begin
                opc = r[31:25];
                if (is_known(opc)) begin
                    opc[0] = ~opc[0];  // Every kept opcode ends in 11
                end
                word              = f;
                word.r_fmt.opcode = opc;
            end
        endcase
        drive_and_check(word, en, rd, res, next_pc);
    endtask

    initial begin
        seed  = 32'h74b2_dac2;
        reset <= 1'b1;
        inst  <= '0;
        model_pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // A writing instruction during reset must stay blocked
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            inst <= encode_i(OPC_OP_IMM, 5'd1, 3'b000, 5'd0, 12'h001);
            @(negedge clk);
            check_pc(RESET_PC);
            check_wb(1'b0, '0, '0);
        end
        load_registers();
        repeat (NUM_INSTR - PRELOAD_INSTR) begin
            run_random();
        end
        $display("Checks done: %0d writeback errors, %0d pc errors", wb_errors, pc_errors);
        if ((wb_errors == 0) && (pc_errors == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/rv_core.sv
test/core_assert.sv
test/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module core_tb -o core_sim
./obj_dir/core_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
